// ==== logic/sd_phy_pkg.sv ====
// Shared constants and types for the SD host PHY, imported by every design module
`default_nettype none

package sd_phy_pkg;

  // Command frame layout
  localparam logic [7:0] CMD_FRAME_BITS = 8'd48;
  // Start, transmission, index and argument
  localparam logic [7:0] CMD_HEAD_BITS  = 8'd40;

  // Response frames
  localparam logic [7:0] RSP_SHORT_BITS    = 8'd48;
  localparam logic [7:0] RSP_LONG_BITS     = 8'd136;
  // Long response header is not covered by CRC7
  localparam logic [7:0] RSP_LONG_HDR_BITS = 8'd8;
  // CRC7 plus end bit at the tail of every response
  localparam logic [7:0] RSP_TAIL_BITS     = 8'd8;
  // Max cycles to wait for a response start bit
  localparam logic [7:0] RSP_TIMEOUT       = 8'd64;

  // Per-lane CRC length on DAT
  localparam logic [4:0] DAT_CRC_BITS = 5'd16;

  // x^7 + x^3 + 1
  localparam logic [6:0]  CRC7_POLY  = 7'h09;
  // x^16 + x^12 + x^5 + 1
  localparam logic [15:0] CRC16_POLY = 16'h1021;

  typedef enum logic [1:0] {
    RSP_NONE  = 2'd0,
    RSP_SHORT = 2'd1,
    RSP_LONG  = 2'd2
  } rsp_kind_t;

  // Command request from the host, 40 bits
  typedef struct packed {
    logic [5:0]  index;
    logic [31:0] arg;
    rsp_kind_t   rsp_kind;
  } sd_cmd_req_t;

  // One byte of the write block plus end marker
  typedef struct packed {
    logic [7:0] data;
    logic       last;
  } sd_byte_t;

endpackage

`default_nettype wire

// ==== logic/sd_crc7.sv ====
// Bit-serial CRC7 for SD command and response frames, fed one bit per enabled cycle
`timescale 1ns/1ps
`default_nettype none

module sd_crc7 import sd_phy_pkg::*; (
  input  wire logic       i_sd_clk,
  input  wire logic       rst,
  input  wire logic       i_clear,
  input  wire logic       i_en,
  input  wire logic       i_bit,
  output logic      [6:0] o_crc
);

  logic fb;

  // MSB-first feedback
  assign fb = i_bit ^ o_crc[6];

  always_ff @(posedge i_sd_clk) begin
    if (rst || i_clear) begin
      o_crc <= '0;
    end else if (i_en) begin
      o_crc <= {o_crc[5:0], 1'b0} ^ (fb ? CRC7_POLY : 7'h00);
    end
  end

endmodule

`default_nettype wire

// ==== logic/sd_crc16.sv ====
// Bit-serial CCITT CRC16 for one DAT lane, one instance per lane in the data transmitter
`timescale 1ns/1ps
`default_nettype none

module sd_crc16 import sd_phy_pkg::*; (
  input  wire logic        i_sd_clk,
  input  wire logic        rst,
  input  wire logic        i_clear,
  input  wire logic        i_en,
  input  wire logic        i_bit,
  output logic      [15:0] o_crc
);

  logic fb;

  // MSB-first feedback
  assign fb = i_bit ^ o_crc[15];

  always_ff @(posedge i_sd_clk) begin
    if (rst || i_clear) begin
      o_crc <= '0;
    end else if (i_en) begin
      o_crc <= {o_crc[14:0], 1'b0} ^ (fb ? CRC16_POLY : 16'h0000);
    end
  end

endmodule

`default_nettype wire

// ==== logic/sd_cmd_engine.sv ====
// CMD line engine: sends a command frame with CRC7, then captures and checks the response
`timescale 1ns/1ps
`default_nettype none

module sd_cmd_engine import sd_phy_pkg::*; (
  input  wire logic          i_sd_clk,
  input  wire logic          rst,
  input  wire logic          i_cmd_stb,
  input  wire sd_cmd_req_t   i_cmd,
  input  wire logic          i_sd_cmd,
  output logic               o_sd_cmd,
  output logic               o_sd_cmd_oe,
  output logic               o_rsp_done,
  output logic     [135:0]   o_rsp,
  output logic               o_rsp_crc_err,
  output logic               o_rsp_timeout
);

  typedef enum logic [2:0] {
    ST_IDLE, ST_SEND, ST_SEND_CRC, ST_WAIT, ST_RECV, ST_CHECK
  } cmd_state_t;

  cmd_state_t  state;
  logic [7:0]  cnt;
  logic [38:0] tx_sr;
  rsp_kind_t   rsp_kind;
  logic [7:0]  rsp_len;
  logic [7:0]  crc_first;
  logic        crc_clr;
  logic        crc_en;
  logic        crc_bit;
  logic [6:0]  crc;
  logic        rx_shift;

  assign rsp_len   = (rsp_kind == RSP_LONG) ? RSP_LONG_BITS : RSP_SHORT_BITS;
  assign crc_first = (rsp_kind == RSP_LONG) ? RSP_LONG_HDR_BITS : 8'd0;
  assign crc_clr   = ((state == ST_SEND_CRC) && (cnt == CMD_FRAME_BITS)) ||
                     (state == ST_CHECK);
  assign rx_shift  = ((state == ST_WAIT) && !i_sd_cmd) || (state == ST_RECV) ||
                     (state == ST_CHECK);

  // CRC sees the bit going out now, or the bit sampled now
  always_comb begin
    crc_en  = 1'b0;
    crc_bit = 1'b0;
    case (state)
      ST_IDLE: crc_en = i_cmd_stb;
      ST_SEND: begin
        crc_en  = 1'b1;
        crc_bit = tx_sr[38];
      end
      ST_WAIT: begin
        // Start bit only counts for short frames
        crc_en  = !i_sd_cmd && (rsp_kind != RSP_LONG);
        crc_bit = i_sd_cmd;
      end
      ST_RECV: begin
        crc_en  = (cnt >= crc_first) && (cnt < rsp_len - RSP_TAIL_BITS);
        crc_bit = i_sd_cmd;
      end
      default: ;
    endcase
  end

  sd_crc7 u_crc7 (
    .i_sd_clk (i_sd_clk),
    .rst      (rst),
    .i_clear  (crc_clr),
    .i_en     (crc_en),
    .i_bit    (crc_bit),
    .o_crc    (crc)
  );

  always_ff @(posedge i_sd_clk) begin
    if (rst) begin
      state         <= ST_IDLE;
      cnt           <= '0;
      tx_sr         <= '0;
      rsp_kind      <= RSP_NONE;
      o_sd_cmd      <= 1'b1;
      o_sd_cmd_oe   <= 1'b0;
      o_rsp_done    <= 1'b0;
      o_rsp_crc_err <= 1'b0;
      o_rsp_timeout <= 1'b0;
    end else begin
      o_rsp_done <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (i_cmd_stb) begin
            // Start bit goes out right away
            o_sd_cmd      <= 1'b0;
            o_sd_cmd_oe   <= 1'b1;
            tx_sr         <= {1'b1, i_cmd.index, i_cmd.arg};
            rsp_kind      <= i_cmd.rsp_kind;
            cnt           <= 8'd1;
            o_rsp_crc_err <= 1'b0;
            o_rsp_timeout <= 1'b0;
            state         <= ST_SEND;
          end
        end
        ST_SEND: begin
          o_sd_cmd <= tx_sr[38];
          tx_sr    <= {tx_sr[37:0], 1'b0};
          cnt      <= cnt + 8'd1;
          if (cnt == CMD_HEAD_BITS - 8'd1) begin
            state <= ST_SEND_CRC;
          end
        end
        ST_SEND_CRC: begin
          cnt <= cnt + 8'd1;
          if (cnt == CMD_HEAD_BITS) begin
            // CRC is final now, queue its tail and the end bit
            o_sd_cmd <= crc[6];
            tx_sr    <= {crc[5:0], 1'b1, 32'd0};
          end else if (cnt < CMD_FRAME_BITS) begin
            o_sd_cmd <= tx_sr[38];
            tx_sr    <= {tx_sr[37:0], 1'b0};
          end else begin
            o_sd_cmd    <= 1'b1;
            o_sd_cmd_oe <= 1'b0;
            cnt         <= '0;
            if (rsp_kind == RSP_NONE) begin
              o_rsp_done <= 1'b1;
              state      <= ST_IDLE;
            end else begin
              state <= ST_WAIT;
            end
          end
        end
        ST_WAIT: begin
          if (!i_sd_cmd) begin
            cnt   <= 8'd1;
            state <= ST_RECV;
          end else if (cnt == RSP_TIMEOUT - 8'd1) begin
            o_rsp_timeout <= 1'b1;
            o_rsp_done    <= 1'b1;
            state         <= ST_IDLE;
          end else begin
            cnt <= cnt + 8'd1;
          end
        end
        ST_RECV: begin
          cnt <= cnt + 8'd1;
          // Bit 1 sampled here, end bit comes next
          if (cnt == rsp_len - 8'd2) begin
            state <= ST_CHECK;
          end
        end
        ST_CHECK: begin
          // Bits 7..1 sit at the bottom of the shift register
          o_rsp_crc_err <= (o_rsp[6:0] != crc);
          o_rsp_done    <= 1'b1;
          state         <= ST_IDLE;
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Response shifts in from the LSB, so it ends right-aligned
  always_ff @(posedge i_sd_clk) begin
    if ((state == ST_IDLE) && i_cmd_stb) begin
      o_rsp <= '0;
    end else if (rx_shift) begin
      o_rsp <= {o_rsp[134:0], i_sd_cmd};
    end
  end

endmodule

`default_nettype wire

// ==== logic/sd_word_unpack.sv ====
// First write stage: pops 32-bit words from the host FIFO and hands out bytes, MSB first
`timescale 1ns/1ps
`default_nettype none

module sd_word_unpack import sd_phy_pkg::*; (
  input  wire logic        i_sd_clk,
  input  wire logic        rst,
  input  wire logic        i_data_stb,
  input  wire logic [11:0] i_data_len,
  input  wire logic        i_h2s_ready,
  input  wire logic [31:0] i_h2s_data,
  input  wire logic        i_byte_req,
  output logic             o_h2s_pop,
  output logic             o_byte_start,
  output sd_byte_t         o_byte
);

  logic        armed;
  logic        active;
  logic [11:0] len_q;
  logic [11:0] blk_len;
  logic        start;
  logic        advance;
  logic [1:0]  idx;
  logic [11:0] rem;
  logic [23:0] word_lo;

  // A strobe with the FIFO already ready starts in the same cycle
  assign blk_len = armed ? len_q : i_data_len;
  assign start   = (armed || (i_data_stb && !active)) && i_h2s_ready;
  assign advance = active && i_byte_req && (rem != 12'd0);

  always_ff @(posedge i_sd_clk) begin
    if (rst) begin
      armed        <= 1'b0;
      active       <= 1'b0;
      len_q        <= '0;
      idx          <= '0;
      rem          <= '0;
      o_h2s_pop    <= 1'b0;
      o_byte_start <= 1'b0;
    end else begin
      o_h2s_pop    <= 1'b0;
      o_byte_start <= 1'b0;
      if (start) begin
        armed        <= 1'b0;
        active       <= 1'b1;
        idx          <= 2'd3;
        rem          <= blk_len - 12'd1;
        o_h2s_pop    <= 1'b1;
        o_byte_start <= 1'b1;
      end else if (i_data_stb && !armed && !active) begin
        // Wait for the FIFO to hold the block
        armed <= 1'b1;
        len_q <= i_data_len;
      end else if (advance) begin
        idx <= idx - 2'd1;
        rem <= rem - 12'd1;
        if (idx == 2'd0) begin
          o_h2s_pop <= 1'b1;
        end
      end else if (active && i_byte_req) begin
        active <= 1'b0;
      end
    end
  end

  // Byte payload
  always_ff @(posedge i_sd_clk) begin
    if (start) begin
      o_byte.data <= i_h2s_data[31:24];
      o_byte.last <= (blk_len == 12'd1);
      word_lo     <= i_h2s_data[23:0];
    end else if (advance) begin
      if (idx == 2'd0) begin
        // FIFO head already moved to the next word
        o_byte.data <= i_h2s_data[31:24];
        word_lo     <= i_h2s_data[23:0];
      end else begin
        o_byte.data <= word_lo[23:16];
        word_lo     <= {word_lo[15:0], 8'h00};
      end
      o_byte.last <= (rem == 12'd1);
    end
  end

endmodule

`default_nettype wire

// ==== logic/sd_dat4_tx.sv ====
// 4-bit DAT transmitter: frames a write block with start nibble, data, lane CRC16s and end
`timescale 1ns/1ps
`default_nettype none

module sd_dat4_tx import sd_phy_pkg::*; (
  input  wire logic     i_sd_clk,
  input  wire logic     rst,
  input  wire logic     i_byte_start,
  input  wire sd_byte_t i_byte,
  output logic          o_byte_req,
  output logic    [3:0] o_sd_dat,
  output logic          o_sd_dat_oe,
  output logic          o_data_done
);

  typedef enum logic [1:0] {
    DAT_IDLE, DAT_DATA, DAT_CRC, DAT_STOP
  } dat_state_t;

  dat_state_t  state;
  // Low nibble when set
  logic        phase;
  logic [4:0]  cnt;
  logic [3:0]  nib;
  logic        crc_en;
  logic        crc_clr;
  logic [15:0] lane_crc [4];

  assign nib        = phase ? i_byte.data[3:0] : i_byte.data[7:4];
  assign o_byte_req = (state == DAT_DATA) && phase;
  assign crc_en     = (state == DAT_DATA);
  assign crc_clr    = (state == DAT_STOP);

  for (genvar g = 0; g < 4; g++) begin : g_lane
    sd_crc16 u_crc16 (
      .i_sd_clk (i_sd_clk),
      .rst      (rst),
      .i_clear  (crc_clr),
      .i_en     (crc_en),
      .i_bit    (nib[g]),
      .o_crc    (lane_crc[g])
    );
  end

  always_ff @(posedge i_sd_clk) begin
    if (rst) begin
      state       <= DAT_IDLE;
      phase       <= 1'b0;
      cnt         <= '0;
      o_sd_dat    <= 4'hF;
      o_sd_dat_oe <= 1'b0;
      o_data_done <= 1'b0;
    end else begin
      o_data_done <= 1'b0;
      case (state)
        DAT_IDLE: begin
          if (i_byte_start) begin
            o_sd_dat    <= 4'h0;
            o_sd_dat_oe <= 1'b1;
            phase       <= 1'b0;
            state       <= DAT_DATA;
          end
        end
        DAT_DATA: begin
          o_sd_dat <= nib;
          phase    <= ~phase;
          if (phase && i_byte.last) begin
            cnt   <= '0;
            state <= DAT_CRC;
          end
        end
        DAT_CRC: begin
          cnt <= cnt + 5'd1;
          if (cnt == DAT_CRC_BITS) begin
            o_sd_dat <= 4'hF;
            state    <= DAT_STOP;
          end else begin
            // All four lanes shift out MSB first together
            for (int l = 0; l < 4; l++) begin
              o_sd_dat[l] <= lane_crc[l][~cnt[3:0]];
            end
          end
        end
        DAT_STOP: begin
          o_sd_dat_oe <= 1'b0;
          o_data_done <= 1'b1;
          state       <= DAT_IDLE;
        end
        default: state <= DAT_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== logic/sd_phy_layer.sv ====
// Top of the SD host PHY, joining the command engine and the write data pipeline to the pins
`timescale 1ns/1ps
`default_nettype none

module sd_phy_layer import sd_phy_pkg::*; (
  input  wire logic          i_sd_clk,
  input  wire logic          rst,
  input  wire logic          i_cmd_stb,
  input  wire sd_cmd_req_t   i_cmd,
  output logic               o_rsp_done,
  output logic     [135:0]   o_rsp,
  output logic               o_rsp_crc_err,
  output logic               o_rsp_timeout,
  input  wire logic          i_data_stb,
  input  wire logic [11:0]   i_data_len,
  output logic               o_data_done,
  input  wire logic          i_h2s_ready,
  input  wire logic [31:0]   i_h2s_data,
  output logic               o_h2s_pop,
  input  wire logic          i_sd_cmd,
  output logic               o_sd_cmd,
  output logic               o_sd_cmd_oe,
  output logic     [3:0]     o_sd_dat,
  output logic               o_sd_dat_oe
);

  logic     byte_start;
  logic     byte_req;
  sd_byte_t byte_q;

  sd_cmd_engine u_cmd_engine (
    .i_sd_clk      (i_sd_clk),
    .rst           (rst),
    .i_cmd_stb     (i_cmd_stb),
    .i_cmd         (i_cmd),
    .i_sd_cmd      (i_sd_cmd),
    .o_sd_cmd      (o_sd_cmd),
    .o_sd_cmd_oe   (o_sd_cmd_oe),
    .o_rsp_done    (o_rsp_done),
    .o_rsp         (o_rsp),
    .o_rsp_crc_err (o_rsp_crc_err),
    .o_rsp_timeout (o_rsp_timeout)
  );

  sd_word_unpack u_word_unpack (
    .i_sd_clk     (i_sd_clk),
    .rst          (rst),
    .i_data_stb   (i_data_stb),
    .i_data_len   (i_data_len),
    .i_h2s_ready  (i_h2s_ready),
    .i_h2s_data   (i_h2s_data),
    .i_byte_req   (byte_req),
    .o_h2s_pop    (o_h2s_pop),
    .o_byte_start (byte_start),
    .o_byte       (byte_q)
  );

  sd_dat4_tx u_dat4_tx (
    .i_sd_clk     (i_sd_clk),
    .rst          (rst),
    .i_byte_start (byte_start),
    .i_byte       (byte_q),
    .o_byte_req   (byte_req),
    .o_sd_dat     (o_sd_dat),
    .o_sd_dat_oe  (o_sd_dat_oe),
    .o_data_done  (o_data_done)
  );

endmodule

`default_nettype wire

// ==== bench/sd_phy_layer_tb.sv ====
// Directed testbench for the SD host PHY, with a card model on CMD and a host FIFO model
`timescale 1ns/1ps
`default_nettype none

module sd_phy_layer_tb import sd_phy_pkg::*; ();

  typedef logic [135:0] val_t;

  logic          i_sd_clk;
  logic          rst;
  logic          i_cmd_stb;
  sd_cmd_req_t   i_cmd;
  logic          o_rsp_done;
  logic [135:0]  o_rsp;
  logic          o_rsp_crc_err;
  logic          o_rsp_timeout;
  logic          i_data_stb;
  logic [11:0]   i_data_len;
  logic          o_data_done;
  logic          i_h2s_ready;
  logic [31:0]   i_h2s_data;
  logic          o_h2s_pop;
  logic          i_sd_cmd;
  logic          o_sd_cmd;
  logic          o_sd_cmd_oe;
  logic [3:0]    o_sd_dat;
  logic          o_sd_dat_oe;

  logic [31:0]   seed;
  logic [31:0]   fifo_mem [4];
  int            fifo_head;
  int            pop_cnt;

  sd_phy_layer i_sd_phy_layer (.*);

  always #2 i_sd_clk = ~i_sd_clk;

  // Host FIFO model whose head word falls through and advances on each pop
  assign i_h2s_data = fifo_mem[fifo_head[1:0]];

  always @(negedge i_sd_clk) begin
    if (rst) begin
      fifo_head = 0;
      pop_cnt   = 0;
    end else if (o_h2s_pop) begin
      fifo_head = fifo_head + 1;
      pop_cnt   = pop_cnt + 1;
    end
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] rand_word();
    seed = lcg_next(seed);
    return seed;
  endfunction

  // x^7 + x^3 + 1 over the low nbits, MSB first
  function automatic logic [6:0] crc7_of(input logic [119:0] bits, input int nbits);
    logic [6:0] c;
    logic       fb;
    c = '0;
    for (int i = nbits - 1; i >= 0; i--) begin
      fb   = bits[i] ^ c[6];
      c    = {c[5:0], fb};
      c[3] = c[3] ^ fb;
    end
    return c;
  endfunction

  // One step of x^16 + x^12 + x^5 + 1
  function automatic logic [15:0] crc16_step(input logic [15:0] c, input logic b);
    logic        fb;
    logic [15:0] n;
    fb    = b ^ c[15];
    n     = {c[14:0], fb};
    n[5]  = n[5] ^ fb;
    n[12] = n[12] ^ fb;
    return n;
  endfunction

  task automatic check_equal(input val_t got, input val_t exp, input string what);
    if (got !== exp) begin
      $display("Fail at %0d ns: %s, got %0h, expected %0h", $time, what, got, exp);
      $display("Test failures found");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic timed_out(input string what);
    $display("Gave up waiting for %s at %0d ns", what, $time);
    $display("Test failures found");
    $fatal(1, "wait limit reached");
  endtask

  task automatic wait_rsp_done(input int limit, output int cycles);
    cycles = 0;
    while (!o_rsp_done && cycles < limit) begin
      @(negedge i_sd_clk);
      cycles++;
    end
    if (!o_rsp_done) begin
      timed_out("response done");
    end
  endtask

  // Strobe a command and capture the 48 bits seen on CMD
  task automatic send_cmd(input logic [5:0] idx, input logic [31:0] arg,
                          input rsp_kind_t kind, output logic [47:0] sent);
    i_cmd.index    = idx;
    i_cmd.arg      = arg;
    i_cmd.rsp_kind = kind;
    i_cmd_stb      = 1'b1;
    @(negedge i_sd_clk);
    i_cmd_stb = 1'b0;
    for (int i = 47; i >= 0; i--) begin
      check_equal(val_t'(o_sd_cmd_oe), val_t'(1), "CMD enable inside frame");
      check_equal(val_t'(o_rsp_done), val_t'(0), "response done during frame");
      sent[i] = o_sd_cmd;
      @(negedge i_sd_clk);
    end
    check_equal(val_t'(o_sd_cmd_oe), val_t'(0), "CMD enable after frame");
  endtask

  // Card drives one response bit per falling edge
  task automatic card_reply(input val_t frame, input int nbits, input int delay);
    repeat (delay) @(negedge i_sd_clk);
    for (int i = nbits - 1; i >= 0; i--) begin
      i_sd_cmd = frame[i];
      @(negedge i_sd_clk);
    end
    i_sd_cmd = 1'b1;
  endtask

  task automatic exchange_rsp(input logic [5:0] idx, input rsp_kind_t kind, input val_t frame,
                              input int nbits, input logic exp_err, input int delay);
    logic [47:0] sent;
    int          cycles;
    send_cmd(idx, rand_word(), kind, sent);
    check_equal(val_t'(o_rsp_done), val_t'(0), "response done before reply");
    card_reply(frame, nbits, delay);
    wait_rsp_done(4, cycles);
    check_equal(val_t'(cycles), val_t'(0), "response done latency");
    check_equal(o_rsp, frame, "received response");
    check_equal(val_t'(o_rsp_crc_err), val_t'(exp_err), "response CRC error flag");
    check_equal(val_t'(o_rsp_timeout), val_t'(0), "response timeout flag");
    @(negedge i_sd_clk);
    check_equal(val_t'(o_rsp_done), val_t'(0), "response done pulse width");
  endtask

  task automatic check_reset_state();
    check_equal(val_t'(o_sd_cmd), val_t'(1), "idle CMD level");
    check_equal(val_t'(o_sd_dat), val_t'(4'hF), "idle DAT level");
    check_equal(val_t'(o_sd_cmd_oe), val_t'(0), "idle CMD enable");
    check_equal(val_t'(o_sd_dat_oe), val_t'(0), "idle DAT enable");
    check_equal(val_t'(o_rsp_done), val_t'(0), "idle response done");
    check_equal(val_t'(o_data_done), val_t'(0), "idle data done");
    check_equal(val_t'(o_h2s_pop), val_t'(0), "idle FIFO pop");
  endtask

  task automatic cmd_no_rsp_test();
    logic [39:0] head;
    logic [47:0] sent;
    logic [31:0] arg;
    arg  = rand_word();
    head = {2'b01, 6'd17, arg};
    send_cmd(6'd17, arg, RSP_NONE, sent);
    check_equal(val_t'(sent), val_t'({head, crc7_of(120'(head), 40), 1'b1}), "command frame");
    check_equal(val_t'(o_rsp_done), val_t'(1), "done after command without response");
    check_equal(val_t'(o_rsp_crc_err), val_t'(0), "CRC flag without response");
    check_equal(val_t'(o_rsp_timeout), val_t'(0), "timeout flag without response");
    @(negedge i_sd_clk);
    check_equal(val_t'(o_rsp_done), val_t'(0), "command done pulse width");
  endtask

  task automatic short_rsp_test(input logic flip_crc);
    logic [39:0] head;
    logic [47:0] rsp;
    head = {2'b00, 6'd13, rand_word()};
    rsp  = {head, crc7_of(120'(head), 40), 1'b1};
    if (flip_crc) begin
      rsp[1] = ~rsp[1];
    end
    exchange_rsp(6'd13, RSP_SHORT, val_t'(rsp), 48, flip_crc, 3);
  endtask

  task automatic long_rsp_test();
    logic [31:0]  w [4];
    logic [119:0] body;
    for (int i = 0; i < 4; i++) begin
      w[i] = rand_word();
    end
    body = {w[0], w[1], w[2], w[3][23:0]};
    // Header 0, 0, 111111 stays outside the CRC
    exchange_rsp(6'd2, RSP_LONG, {8'h3F, body, crc7_of(body, 120), 1'b1}, 136, 1'b0, 5);
  endtask

  task automatic rsp_timeout_test();
    logic [47:0] sent;
    int          cycles;
    send_cmd(6'd9, rand_word(), RSP_SHORT, sent);
    wait_rsp_done(int'(RSP_TIMEOUT) + 8, cycles);
    check_equal(val_t'(cycles >= int'(RSP_TIMEOUT)), val_t'(1), "timeout before its limit");
    check_equal(val_t'(o_rsp_timeout), val_t'(1), "response timeout flag");
    check_equal(val_t'(o_rsp_crc_err), val_t'(0), "CRC flag on timeout");
    @(negedge i_sd_clk);
  endtask

  task automatic write_block_test();
    logic [7:0]  blk_bytes [16];
    logic [3:0]  nibs [64];
    logic [3:0]  exp_nib [50];
    logic [15:0] crc;
    int          n;
    int          waited;
    for (int w = 0; w < 4; w++) begin
      fifo_mem[w] = rand_word();
      for (int b = 0; b < 4; b++) begin
        blk_bytes[w * 4 + b] = fifo_mem[w][31 - 8 * b -: 8];
      end
    end
    i_data_len = 12'd16;
    i_data_stb = 1'b1;
    @(negedge i_sd_clk);
    i_data_stb = 1'b0;
    // FIFO fills a few cycles late
    repeat (5) @(negedge i_sd_clk);
    check_equal(val_t'(o_h2s_pop), val_t'(0), "pop before FIFO ready");
    i_h2s_ready = 1'b1;
    @(negedge i_sd_clk);
    check_equal(val_t'(o_h2s_pop), val_t'(1), "first word pop");
    waited = 0;
    while (!o_sd_dat_oe && waited < 8) begin
      @(negedge i_sd_clk);
      waited++;
    end
    if (!o_sd_dat_oe) begin
      timed_out("DAT output enable");
    end
    n = 0;
    while (o_sd_dat_oe && n < 64) begin
      check_equal(val_t'(o_data_done), val_t'(0), "data done inside block");
      nibs[n] = o_sd_dat;
      n++;
      @(negedge i_sd_clk);
    end
    check_equal(val_t'(n), val_t'(2 * 16 + 18), "DAT enable span");
    check_equal(val_t'(o_data_done), val_t'(1), "data done after block");
    check_equal(val_t'(pop_cnt), val_t'(4), "FIFO pop count");
    i_h2s_ready = 1'b0;

    exp_nib[0] = 4'h0;
    for (int i = 0; i < 16; i++) begin
      exp_nib[1 + 2 * i] = blk_bytes[i][7:4];
      exp_nib[2 + 2 * i] = blk_bytes[i][3:0];
    end
    for (int l = 0; l < 4; l++) begin
      crc = '0;
      for (int k = 1; k <= 32; k++) begin
        crc = crc16_step(crc, exp_nib[k][l]);
      end
      for (int k = 0; k < 16; k++) begin
        exp_nib[33 + k][l] = crc[15 - k];
      end
    end
    exp_nib[49] = 4'hF;
    for (int k = 0; k < 50; k++) begin
      check_equal(val_t'(nibs[k]), val_t'(exp_nib[k]), $sformatf("DAT nibble %0d", k));
    end
    @(negedge i_sd_clk);
    check_equal(val_t'(o_data_done), val_t'(0), "data done pulse width");
  endtask

  initial begin
    i_sd_clk    = 1'b0;
    rst         = 1'b1;
    i_cmd_stb   = 1'b0;
    i_cmd       = '0;
    i_data_stb  = 1'b0;
    i_data_len  = '0;
    i_h2s_ready = 1'b0;
    i_sd_cmd    = 1'b1;
    seed        = 32'd41;
    for (int w = 0; w < 4; w++) begin
      fifo_mem[w] = 32'hC3C3_0000 | 32'(w);
    end
    repeat (4) @(posedge i_sd_clk);
    @(negedge i_sd_clk);
    rst = 1'b0;

    check_reset_state();
    cmd_no_rsp_test();
    short_rsp_test(1'b0);
    short_rsp_test(1'b1);
    long_rsp_test();
    rsp_timeout_test();
    write_block_test();

    $display("All tests passed!");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
logic/sd_phy_pkg.sv
logic/sd_crc7.sv
logic/sd_crc16.sv
logic/sd_cmd_engine.sv
logic/sd_word_unpack.sv
logic/sd_dat4_tx.sv
logic/sd_phy_layer.sv
bench/sd_phy_layer_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= sd_phy_layer_tb
FLIST     ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
